/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------

// Byte address width on both ports
`define CACHE_W_ADDR    32
// One bus word is one cache line
`define CACHE_W_DATA    32

// ------------------------------------------------------------
// Cache geometry
// ------------------------------------------------------------

// Number of lines in the direct-mapped store
`define CACHE_DEPTH     64
// Address split: tag | index | byte offset
`define CACHE_W_INDEX   6
`define CACHE_W_OFFSET  2
`define CACHE_W_TAG     24

`endif

/* ahb_lite_pkg.sv */
`default_nettype none

package ahb_lite_pkg;

// ------------------------------------------------------------
// Transfer type
// ------------------------------------------------------------

// Bit 1 set marks an active transfer
// Only single NONSEQ transfers are used on either port
typedef enum logic [1:0] {
	IDLE   = 2'b00,
	NONSEQ = 2'b10
} htrans_t;

// ------------------------------------------------------------
// Transfer size
// ------------------------------------------------------------

// Encodes log2 of the byte count
// Anything above WORD is not supported on a 32-bit bus
typedef enum logic [2:0] {
	BYTE = 3'b000,
	HALF = 3'b001,
	WORD = 3'b010
} hsize_t;

endpackage

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

// ------------------------------------------------------------
// Address fields and payloads
// ------------------------------------------------------------

typedef logic [`CACHE_W_INDEX-1:0] index_t;
typedef logic [`CACHE_W_TAG-1:0]   tag_t;
typedef logic [`CACHE_W_DATA-1:0]  word_t;

// One tag store entry
// valid clear means the line holds nothing
typedef struct packed {
	logic valid;
	logic dirty;
	tag_t tag;
} tag_entry_t;

// ------------------------------------------------------------
// Controller states
// ------------------------------------------------------------

typedef enum logic [3:0] {
	IDLE,        // No upstream data phase open
	READ_CHECK,  // Tag and data read results valid
	READ_CLEAN,  // Victim write-back data phase, fill address phase
	READ_FILL,   // Fill data phase for a read
	READ_DONE,   // Response from the captured fill word
	WRITE_CHECK, // Tag valid, hit writes merged word here
	WRITE_CLEAN, // Victim write-back data phase, fill address phase
	WRITE_FILL,  // Fill data phase, merged dirty line written on completion
	WRITE_DONE   // Response cycle after a write
} ctrl_state_t;

endpackage

`default_nettype wire

/* cache_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_ram #(
	parameter type payload_t = cache_pkg::word_t,
	parameter int  DEPTH     = `CACHE_DEPTH
) (
	input  logic              clk,
	input  logic              rst_n,
	input  cache_pkg::index_t index,
	input  logic              ren,
	input  logic              wen,
	input  payload_t          wdata,
	output payload_t          rdata
);

// ------------------------------------------------------------
// Storage
// ------------------------------------------------------------

payload_t         mem [DEPTH];
// Set on first write to a line
// Cleared as a whole on reset so the array itself needs no reset
logic [DEPTH-1:0] line_valid;

always_ff @(posedge clk) begin
	if (wen)
		mem[index] <= wdata;
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		line_valid <= '0;
	end else if (wen) begin
		line_valid[index] <= 1'b1;
	end
end

// ------------------------------------------------------------
// Registered read
// ------------------------------------------------------------

// A line never written reads as zero
// For a tag entry that is a clear valid bit
// Output holds until the next read enable
always_ff @(posedge clk) begin
	if (ren)
		rdata <= line_valid[index] ? mem[index] : payload_t'(0);
end

// Single port: the controller must not read and write in one cycle
assert property (@(posedge clk) disable iff (!rst_n) !(ren && wen))
	else $error("cache_ram: read and write in the same cycle");

endmodule

`default_nettype wire

/* ahb_cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module ahb_cache_ctrl (
	input  logic                     clk,
	input  logic                     rst_n,

	// Upstream AHB-Lite subordinate port
	input  logic                     src_hready,
	input  logic [`CACHE_W_ADDR-1:0] src_haddr,
	input  logic                     src_hwrite,
	input  ahb_lite_pkg::htrans_t    src_htrans,
	input  ahb_lite_pkg::hsize_t     src_hsize,
	input  logic [`CACHE_W_DATA-1:0] src_hwdata,
	output logic                     src_hready_resp,
	output logic [`CACHE_W_DATA-1:0] src_hrdata,

	// Downstream AHB-Lite manager port
	output logic [`CACHE_W_ADDR-1:0] dst_haddr,
	output ahb_lite_pkg::htrans_t    dst_htrans,
	output logic                     dst_hwrite,
	output ahb_lite_pkg::hsize_t     dst_hsize,
	output logic [`CACHE_W_DATA-1:0] dst_hwdata,
	output logic                     dst_hready,
	input  logic                     dst_hready_resp,
	input  logic                     dst_hresp,
	input  logic [`CACHE_W_DATA-1:0] dst_hrdata,

	// Tag RAM
	output cache_pkg::index_t        tag_index,
	output logic                     tag_ren,
	output logic                     tag_wen,
	output cache_pkg::tag_entry_t    tag_wdata,
	input  cache_pkg::tag_entry_t    tag_rdata,

	// Data RAM
	output cache_pkg::index_t        data_index,
	output logic                     data_ren,
	output logic                     data_wen,
	output cache_pkg::word_t         data_wdata,
	input  cache_pkg::word_t         data_rdata
);

localparam int N_BYTES = `CACHE_W_DATA / 8;

cache_pkg::ctrl_state_t   state;
cache_pkg::ctrl_state_t   state_next_or_idle;

logic [`CACHE_W_ADDR-1:0] addr_q;
ahb_lite_pkg::hsize_t     size_q;
cache_pkg::word_t         fill_data_q;

logic                     accept;
cache_pkg::tag_t          addr_tag;
cache_pkg::index_t        addr_index;
cache_pkg::index_t        ram_index;
logic                     ram_wen;

logic                     hit;
logic                     dirty;
logic                     in_check;
logic                     in_clean;
logic                     in_fill;
logic                     in_write;
logic                     wb_aphase;
logic                     modify_hit;
logic                     fill_done;

logic [`CACHE_W_ADDR-1:0] fill_addr;
logic [`CACHE_W_ADDR-1:0] victim_addr;
logic [N_BYTES-1:0]       byte_mask;
cache_pkg::word_t         merge_base;
cache_pkg::word_t         merged;

// ------------------------------------------------------------
// Upstream address phase
// ------------------------------------------------------------

// Only taken while our own response is ready
// so a RAM read never lands on a RAM write cycle
assign accept = src_hready && src_htrans[1] && src_hready_resp;

assign state_next_or_idle =
	!accept    ? cache_pkg::IDLE :
	src_hwrite ? cache_pkg::WRITE_CHECK : cache_pkg::READ_CHECK;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		addr_q <= '0;
		size_q <= ahb_lite_pkg::BYTE;
	end else if (accept) begin
		addr_q <= src_haddr;
		size_q <= src_hsize;
	end
end

assign addr_tag   = addr_q[`CACHE_W_ADDR-1 -: `CACHE_W_TAG];
assign addr_index = addr_q[`CACHE_W_OFFSET +: `CACHE_W_INDEX];

// ------------------------------------------------------------
// Hit and dirty check
// ------------------------------------------------------------

// Tag RAM output holds from the address phase read until the next accept
assign hit   = tag_rdata.valid && (tag_rdata.tag == addr_tag);
assign dirty = tag_rdata.valid && tag_rdata.dirty;

assign in_check = (state == cache_pkg::READ_CHECK) || (state == cache_pkg::WRITE_CHECK);
assign in_clean = (state == cache_pkg::READ_CLEAN) || (state == cache_pkg::WRITE_CLEAN);
assign in_fill  = (state == cache_pkg::READ_FILL)  || (state == cache_pkg::WRITE_FILL);
// States whose RAM update carries upstream write bytes
assign in_write = (state == cache_pkg::WRITE_CHECK) || (state == cache_pkg::WRITE_FILL);

// Victim write-back goes out from the check cycle
assign wb_aphase  = in_check && !hit && dirty;
assign modify_hit = (state == cache_pkg::WRITE_CHECK) && hit;
assign fill_done  = in_fill && dst_hready;

// ------------------------------------------------------------
// Controller FSM
// ------------------------------------------------------------

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= cache_pkg::IDLE;
	end else begin
		case (state)
		cache_pkg::IDLE,
		cache_pkg::READ_DONE,
		cache_pkg::WRITE_DONE: begin
			state <= state_next_or_idle;
		end
		cache_pkg::READ_CHECK: begin
			// Hit answers this cycle and may take the next address phase
			if (hit)
				state <= state_next_or_idle;
			else if (dst_hready)
				state <= dirty ? cache_pkg::READ_CLEAN : cache_pkg::READ_FILL;
		end
		cache_pkg::WRITE_CHECK: begin
			// Hit writes now and answers after one wait state
			if (hit)
				state <= cache_pkg::WRITE_DONE;
			else if (dst_hready)
				state <= dirty ? cache_pkg::WRITE_CLEAN : cache_pkg::WRITE_FILL;
		end
		cache_pkg::READ_CLEAN: if (dst_hready) begin
			state <= cache_pkg::READ_FILL;
		end
		cache_pkg::READ_FILL: if (dst_hready) begin
			state <= cache_pkg::READ_DONE;
		end
		cache_pkg::WRITE_CLEAN: if (dst_hready) begin
			state <= cache_pkg::WRITE_FILL;
		end
		cache_pkg::WRITE_FILL: if (dst_hready) begin
			state <= cache_pkg::WRITE_DONE;
		end
		default: begin
			state <= cache_pkg::IDLE;
		end
		endcase
	end
end

// ------------------------------------------------------------
// Tag and data RAM controls
// ------------------------------------------------------------

// Fresh index during an address phase, registered one otherwise
// Victim shares the index so the write-back needs no other read
assign ram_index = accept ? src_haddr[`CACHE_W_OFFSET +: `CACHE_W_INDEX] : addr_index;
assign ram_wen   = modify_hit || fill_done;

assign tag_index  = ram_index;
assign tag_ren    = accept;
assign tag_wen    = ram_wen;
assign tag_wdata  = '{valid: 1'b1, dirty: in_write, tag: addr_tag};

assign data_index = ram_index;
assign data_ren   = accept;
assign data_wen   = ram_wen;

// Byte lanes touched by the upstream write
always_comb begin
	case (size_q)
	ahb_lite_pkg::BYTE: byte_mask = N_BYTES'(1) << addr_q[`CACHE_W_OFFSET-1:0];
	ahb_lite_pkg::HALF: byte_mask = N_BYTES'(3) << addr_q[`CACHE_W_OFFSET-1:0];
	default:            byte_mask = '1;
	endcase
end

// Hit merges into the cached word
// Write fill merges into the word arriving from downstream
assign merge_base = (state == cache_pkg::WRITE_CHECK) ? data_rdata : dst_hrdata;

always_comb begin
	merged = merge_base;
	for (int i = 0; i < N_BYTES; i++) begin
		if (byte_mask[i])
			merged[8*i +: 8] = src_hwdata[8*i +: 8];
	end
end

assign data_wdata = in_write ? merged : merge_base;

// ------------------------------------------------------------
// Downstream request
// ------------------------------------------------------------

assign fill_addr   = {addr_q[`CACHE_W_ADDR-1:`CACHE_W_OFFSET], {`CACHE_W_OFFSET{1'b0}}};
assign victim_addr = {tag_rdata.tag, addr_index, {`CACHE_W_OFFSET{1'b0}}};

// Fill address phase overlaps the write-back data phase in CLEAN
assign dst_haddr  = wb_aphase ? victim_addr : fill_addr;
assign dst_htrans = ((in_check && !hit) || in_clean) ? ahb_lite_pkg::NONSEQ
                                                     : ahb_lite_pkg::IDLE;
assign dst_hwrite = wb_aphase;
assign dst_hsize  = ahb_lite_pkg::WORD;
// Victim word stays on the data RAM output through the write-back
assign dst_hwdata = data_rdata;
assign dst_hready = dst_hready_resp;

// ------------------------------------------------------------
// Upstream response
// ------------------------------------------------------------

// Read fill word is registered and returned a cycle later
always_ff @(posedge clk) begin
	if ((state == cache_pkg::READ_FILL) && dst_hready)
		fill_data_q <= dst_hrdata;
end

assign src_hrdata = (state == cache_pkg::READ_DONE) ? fill_data_q : data_rdata;

assign src_hready_resp =
	(state == cache_pkg::IDLE) ||
	((state == cache_pkg::READ_CHECK) && hit) ||
	(state == cache_pkg::READ_DONE) ||
	(state == cache_pkg::WRITE_DONE);

// ------------------------------------------------------------
// Checks
// ------------------------------------------------------------

// Error responses are not handled by this cache
assert property (@(posedge clk) disable iff (!rst_n) !(dst_hready && dst_hresp))
	else $error("ahb_cache_ctrl: downstream ERROR response");

assert property (@(posedge clk) disable iff (!rst_n)
	accept |-> (src_hsize <= ahb_lite_pkg::WORD))
	else $error("ahb_cache_ctrl: transfer wider than the bus");

// Natural alignment keeps every access inside one line
assert property (@(posedge clk) disable iff (!rst_n)
	accept |-> ((src_hsize == ahb_lite_pkg::BYTE) ||
	            ((src_hsize == ahb_lite_pkg::HALF) && !src_haddr[0]) ||
	            (src_haddr[`CACHE_W_OFFSET-1:0] == '0)))
	else $error("ahb_cache_ctrl: unaligned transfer");

endmodule

`default_nettype wire

/* ahb_writeback_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module ahb_writeback_cache (
	input  logic                     clk,
	input  logic                     rst_n,

	// Upstream AHB-Lite subordinate port
	input  logic                     src_hready,
	input  logic [`CACHE_W_ADDR-1:0] src_haddr,
	input  logic                     src_hwrite,
	input  ahb_lite_pkg::htrans_t    src_htrans,
	input  ahb_lite_pkg::hsize_t     src_hsize,
	input  logic [`CACHE_W_DATA-1:0] src_hwdata,
	output logic                     src_hready_resp,
	output logic [`CACHE_W_DATA-1:0] src_hrdata,

	// Downstream AHB-Lite manager port
	output logic [`CACHE_W_ADDR-1:0] dst_haddr,
	output ahb_lite_pkg::htrans_t    dst_htrans,
	output logic                     dst_hwrite,
	output ahb_lite_pkg::hsize_t     dst_hsize,
	output logic [`CACHE_W_DATA-1:0] dst_hwdata,
	output logic                     dst_hready,
	input  logic                     dst_hready_resp,
	input  logic                     dst_hresp,
	input  logic [`CACHE_W_DATA-1:0] dst_hrdata
);

// Tag store side
cache_pkg::index_t     tag_index;
logic                  tag_ren;
logic                  tag_wen;
cache_pkg::tag_entry_t tag_wdata;
cache_pkg::tag_entry_t tag_rdata;

// Data store side
cache_pkg::index_t     data_index;
logic                  data_ren;
logic                  data_wen;
cache_pkg::word_t      data_wdata;
cache_pkg::word_t      data_rdata;

ahb_cache_ctrl ctrl_i (
	.clk             (clk),
	.rst_n           (rst_n),
	.src_hready      (src_hready),
	.src_haddr       (src_haddr),
	.src_hwrite      (src_hwrite),
	.src_htrans      (src_htrans),
	.src_hsize       (src_hsize),
	.src_hwdata      (src_hwdata),
	.src_hready_resp (src_hready_resp),
	.src_hrdata      (src_hrdata),
	.dst_haddr       (dst_haddr),
	.dst_htrans      (dst_htrans),
	.dst_hwrite      (dst_hwrite),
	.dst_hsize       (dst_hsize),
	.dst_hwdata      (dst_hwdata),
	.dst_hready      (dst_hready),
	.dst_hready_resp (dst_hready_resp),
	.dst_hresp       (dst_hresp),
	.dst_hrdata      (dst_hrdata),
	.tag_index       (tag_index),
	.tag_ren         (tag_ren),
	.tag_wen         (tag_wen),
	.tag_wdata       (tag_wdata),
	.tag_rdata       (tag_rdata),
	.data_index      (data_index),
	.data_ren        (data_ren),
	.data_wen        (data_wen),
	.data_wdata      (data_wdata),
	.data_rdata      (data_rdata)
);

// Both stores are read in the same address phase cycle
cache_ram #(
	.payload_t (cache_pkg::tag_entry_t),
	.DEPTH     (`CACHE_DEPTH)
) tag_ram_i (
	.clk   (clk),
	.rst_n (rst_n),
	.index (tag_index),
	.ren   (tag_ren),
	.wen   (tag_wen),
	.wdata (tag_wdata),
	.rdata (tag_rdata)
);

cache_ram #(
	.payload_t (cache_pkg::word_t),
	.DEPTH     (`CACHE_DEPTH)
) data_ram_i (
	.clk   (clk),
	.rst_n (rst_n),
	.index (data_index),
	.ren   (data_ren),
	.wen   (data_wen),
	.wdata (data_wdata),
	.rdata (data_rdata)
);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

// 10 ns period, first rising edge at 5 ns
initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

// Reset held for 8 cycles
// Released on a falling edge, well clear of the rising edge
initial begin
	rst_n = 1'b0;
	repeat (8) @(negedge clk);
	rst_n = 1'b1;
end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tb_checker (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     src_hready,
	input  ahb_lite_pkg::htrans_t    src_htrans,
	input  logic                     src_hwrite,
	input  logic                     src_hready_resp,
	input  logic [`CACHE_W_DATA-1:0] src_hrdata,
	input  logic                     dst_hready,
	input  ahb_lite_pkg::htrans_t    dst_htrans,
	input  logic                     dst_hwrite,
	input  ahb_lite_pkg::hsize_t     dst_hsize,
	input  int                       exp_entry,
	input  logic [`CACHE_W_DATA-1:0] exp_rdata,
	input  logic [`CACHE_W_DATA-1:0] exp_mask,
	input  int                       exp_wr,
	input  int                       exp_rd,
	output int                       n_done,
	output int                       n_failed
);

// Upstream data phase in progress and its direction
logic phase_open;
logic phase_read;
// Write-back seen after the fill read
logic order_bad;
// Downstream size other than a word seen during the open transfer
logic size_bad;
// Downstream address phases during the open transfer
int   dst_wr_seen;
int   dst_rd_seen;

initial begin
	phase_open  = 1'b0;
	phase_read  = 1'b0;
	order_bad   = 1'b0;
	size_bad    = 1'b0;
	dst_wr_seen = 0;
	dst_rd_seen = 0;
	n_done      = 0;
	n_failed    = 0;
end

// Compare one finished transfer with its table row
task automatic finish_entry();
	logic bad;
	bad = order_bad || size_bad;
	// Only the lanes of the transfer size carry read data
	if (phase_read && ((src_hrdata & exp_mask) !== (exp_rdata & exp_mask))) begin
		$display("MISMATCH at %0t: entry %0d read data %h, expected %h",
			$time, exp_entry, src_hrdata & exp_mask, exp_rdata & exp_mask);
		bad = 1'b1;
	end
	if (dst_wr_seen != exp_wr) begin
		$display("MISMATCH at %0t: entry %0d saw %0d downstream writes, expected %0d",
			$time, exp_entry, dst_wr_seen, exp_wr);
		bad = 1'b1;
	end
	if (dst_rd_seen != exp_rd) begin
		$display("MISMATCH at %0t: entry %0d saw %0d downstream reads, expected %0d",
			$time, exp_entry, dst_rd_seen, exp_rd);
		bad = 1'b1;
	end
	n_done++;
	if (bad)
		n_failed++;
	$display("Entry %0d %s: %0d downstream writes, %0d downstream reads",
		exp_entry, bad ? "failed" : "ok", dst_wr_seen, dst_rd_seen);
endtask

// ------------------------------------------------------------
// Sampling on the rising edge
// ------------------------------------------------------------

always @(posedge clk) begin
	if (rst_n) begin
		// Count downstream address phases by direction
		if (dst_hready && dst_htrans[1]) begin
			// Downstream traffic only ever serves an open upstream transfer
			if (!phase_open) begin
				$display("Downstream transfer issued with no upstream transfer open");
				n_failed++;
			end
			// Every downstream transfer is a single word
			if (dst_hsize != ahb_lite_pkg::WORD) begin
				$display("MISMATCH at %0t: entry %0d downstream size %0d, expected %0d",
					$time, exp_entry, dst_hsize, ahb_lite_pkg::WORD);
				size_bad = 1'b1;
			end
			if (dst_hwrite) begin
				// Victim write-back has to come before the fill
				if (dst_rd_seen != 0) begin
					$display("Entry %0d: downstream write issued after the fill read", exp_entry);
					order_bad = 1'b1;
				end
				dst_wr_seen++;
			end else begin
				dst_rd_seen++;
			end
		end
		// Data phase ends on a ready edge
		if (phase_open && src_hready_resp) begin
			finish_entry();
			phase_open = 1'b0;
		end
		// New upstream address phase opens the next transfer
		if (src_hready && src_htrans[1] && src_hready_resp) begin
			phase_open  = 1'b1;
			phase_read  = !src_hwrite;
			order_bad   = 1'b0;
			size_bad    = 1'b0;
			dst_wr_seen = 0;
			dst_rd_seen = 0;
		end
	end
end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tb_top;

localparam int   N_ENTRIES     = 17;
localparam int   CLK_PERIOD_NS = 10;
// Model covers the low 4 KB, enough for every table address
localparam int   MEM_WORDS     = 1024;
localparam logic RD            = 1'b0;
localparam logic WR            = 1'b1;

logic                     clk;
logic                     rst_n;

// Upstream port
logic                     src_hready;
logic [`CACHE_W_ADDR-1:0] src_haddr;
logic                     src_hwrite;
ahb_lite_pkg::htrans_t    src_htrans;
ahb_lite_pkg::hsize_t     src_hsize;
logic [`CACHE_W_DATA-1:0] src_hwdata;
logic                     src_hready_resp;
logic [`CACHE_W_DATA-1:0] src_hrdata;

// Downstream port
logic [`CACHE_W_ADDR-1:0] dst_haddr;
ahb_lite_pkg::htrans_t    dst_htrans;
logic                     dst_hwrite;
ahb_lite_pkg::hsize_t     dst_hsize;
logic [`CACHE_W_DATA-1:0] dst_hwdata;
logic                     dst_hready;
logic                     dst_hready_resp;
logic                     dst_hresp;
logic [`CACHE_W_DATA-1:0] dst_hrdata;

// Row under test, handed to the checker
int                       exp_entry;
logic [`CACHE_W_DATA-1:0] exp_rdata;
logic [`CACHE_W_DATA-1:0] exp_mask;
int                       exp_wr;
int                       exp_rd;
int                       n_done;
int                       n_failed;

// Stimulus table
logic                     tbl_write [N_ENTRIES];
logic [`CACHE_W_ADDR-1:0] tbl_addr  [N_ENTRIES];
ahb_lite_pkg::hsize_t     tbl_size  [N_ENTRIES];
logic [`CACHE_W_DATA-1:0] tbl_wdata [N_ENTRIES];
logic [`CACHE_W_DATA-1:0] tbl_rdata [N_ENTRIES];
int                       tbl_wr    [N_ENTRIES];
int                       tbl_rd    [N_ENTRIES];
int                       n_tbl;

// Downstream memory model state
logic [`CACHE_W_DATA-1:0] dmem [MEM_WORDS];
logic                     dph_open;
logic                     dph_write;
logic [`CACHE_W_ADDR-1:0] dph_addr;
int                       dph_wait;
int                       model_errors;
integer                   seed;

tb_clock_gen clock_i (.*);
ahb_writeback_cache dut_i (.*);
tb_checker checker_i (.*);

// Upstream ready looped back from the response
assign src_hready = src_hready_resp;

task automatic add_entry(input logic wr, input logic [`CACHE_W_ADDR-1:0] addr,
		input ahb_lite_pkg::hsize_t size, input logic [`CACHE_W_DATA-1:0] wdata,
		input logic [`CACHE_W_DATA-1:0] rdata, input int n_wr, input int n_rd);
	tbl_write[n_tbl] = wr;
	tbl_addr[n_tbl]  = addr;
	tbl_size[n_tbl]  = size;
	tbl_wdata[n_tbl] = wdata;
	tbl_rdata[n_tbl] = rdata;
	tbl_wr[n_tbl]    = n_wr;
	tbl_rd[n_tbl]    = n_rd;
	n_tbl++;
endtask

// AHB byte lanes of a transfer
function automatic logic [`CACHE_W_DATA-1:0] lane_mask(input logic [`CACHE_W_ADDR-1:0] addr,
		input ahb_lite_pkg::hsize_t size);
	case (size)
	ahb_lite_pkg::BYTE: return 32'h0000_00ff << (8 * addr[1:0]);
	ahb_lite_pkg::HALF: return 32'h0000_ffff << (8 * addr[1:0]);
	default:            return '1;
	endcase
endfunction

// One upstream transfer, address phase then data phase
task automatic apply_entry(input int i);
	@(negedge clk);
	src_haddr  = tbl_addr[i];
	src_hwrite = tbl_write[i];
	src_hsize  = tbl_size[i];
	src_hwdata = tbl_wdata[i];
	src_htrans = ahb_lite_pkg::NONSEQ;
	exp_entry  = i;
	exp_rdata  = tbl_rdata[i];
	exp_mask   = lane_mask(tbl_addr[i], tbl_size[i]);
	exp_wr     = tbl_wr[i];
	exp_rd     = tbl_rd[i];
	// Address phase taken on the rising edge in between
	@(negedge clk);
	src_htrans = ahb_lite_pkg::IDLE;
	while (!src_hready_resp)
		@(negedge clk);
	// Data phase ends here
	@(posedge clk);
endtask

// ------------------------------------------------------------
// Downstream memory model
// ------------------------------------------------------------

// Address and write data sampled on the rising edge
always @(posedge clk) begin
	if (rst_n) begin
		if (dph_open && dst_hready) begin
			if (dph_write)
				dmem[dph_addr[11:2]] = dst_hwdata;
			dph_open = 1'b0;
		end
		if (dst_hready && dst_htrans[1]) begin
			if (dst_haddr >= MEM_WORDS * 4 || dst_haddr[1:0] != 2'b00) begin
				$display("Downstream address %h is unaligned or outside the memory model",
					dst_haddr);
				model_errors++;
			end
			dph_open  = 1'b1;
			dph_write = dst_hwrite;
			dph_addr  = dst_haddr;
			// 0 to 3 wait states
			dph_wait  = $random(seed) & 3;
		end
	end
end

// Ready and read data driven on the falling edge
always @(negedge clk) begin
	if (dph_open && dph_wait > 0) begin
		dst_hready_resp = 1'b0;
		dph_wait--;
	end else begin
		dst_hready_resp = 1'b1;
		dst_hrdata      = (dph_open && !dph_write) ? dmem[dph_addr[11:2]] : '0;
	end
end

// ------------------------------------------------------------
// Stimulus
// ------------------------------------------------------------

initial begin
	seed            = 32'h5414_06f2;
	src_haddr       = '0;
	src_hwrite      = 1'b0;
	src_htrans      = ahb_lite_pkg::IDLE;
	src_hsize       = ahb_lite_pkg::WORD;
	src_hwdata      = '0;
	dst_hready_resp = 1'b1;
	dst_hresp       = 1'b0;
	dst_hrdata      = '0;
	exp_entry       = 0;
	exp_rdata       = '0;
	exp_mask        = '0;
	exp_wr          = 0;
	exp_rd          = 0;
	dph_open        = 1'b0;
	dph_write       = 1'b0;
	dph_addr        = '0;
	dph_wait        = 0;
	model_errors    = 0;
	n_tbl           = 0;
	// Memory starts as the inverted byte address of each word
	for (int i = 0; i < MEM_WORDS; i++)
		dmem[i] = ~(i * 4);

	// Cold read miss, then a hit on the same word
	add_entry(RD, 32'h0000_0040, ahb_lite_pkg::WORD, 32'h0,         32'hffff_ffbf, 0, 1);
	add_entry(RD, 32'h0000_0040, ahb_lite_pkg::WORD, 32'h0,         32'hffff_ffbf, 0, 0);
	// Byte and halfword write hits merged into the cached word
	add_entry(WR, 32'h0000_0041, ahb_lite_pkg::BYTE, 32'h0000_5a00, 32'h0,         0, 0);
	add_entry(WR, 32'h0000_0042, ahb_lite_pkg::HALF, 32'h1234_0000, 32'h0,         0, 0);
	add_entry(RD, 32'h0000_0040, ahb_lite_pkg::WORD, 32'h0,         32'h1234_5abf, 0, 0);
	// Same index, new tag: write-back of the dirty word, then a fill
	add_entry(RD, 32'h0000_0140, ahb_lite_pkg::WORD, 32'h0,         32'hffff_febf, 1, 1);
	add_entry(RD, 32'h0000_0040, ahb_lite_pkg::WORD, 32'h0,         32'h1234_5abf, 0, 1);
	// Write miss to a cold line fills and merges
	add_entry(WR, 32'h0000_0083, ahb_lite_pkg::BYTE, 32'hc300_0000, 32'h0,         0, 1);
	add_entry(RD, 32'h0000_0080, ahb_lite_pkg::WORD, 32'h0,         32'hc3ff_ff7f, 0, 0);
	// Write miss over a dirty victim
	add_entry(WR, 32'h0000_0180, ahb_lite_pkg::WORD, 32'hdead_beef, 32'h0,         1, 1);
	add_entry(RD, 32'h0000_0182, ahb_lite_pkg::HALF, 32'h0,         32'hdead_beef, 0, 0);
	add_entry(RD, 32'h0000_0081, ahb_lite_pkg::BYTE, 32'h0,         32'hc3ff_ff7f, 1, 1);
	add_entry(RD, 32'h0000_0180, ahb_lite_pkg::WORD, 32'h0,         32'hdead_beef, 0, 1);
	// Index 0, halfword write miss then a dirty read miss
	add_entry(WR, 32'h0000_0000, ahb_lite_pkg::HALF, 32'h0000_7777, 32'h0,         0, 1);
	add_entry(RD, 32'h0000_0000, ahb_lite_pkg::WORD, 32'h0,         32'hffff_7777, 0, 0);
	add_entry(RD, 32'h0000_0100, ahb_lite_pkg::WORD, 32'h0,         32'hffff_feff, 1, 1);
	add_entry(RD, 32'h0000_0000, ahb_lite_pkg::WORD, 32'h0,         32'hffff_7777, 0, 1);

	wait (rst_n === 1'b1);
	for (int i = 0; i < n_tbl; i++)
		apply_entry(i);
	@(negedge clk);

	$display("Summary: %0d of %0d entries run, %0d failed, %0d memory model errors",
		n_done, n_tbl, n_failed, model_errors);
	if (n_done == n_tbl && n_failed == 0 && model_errors == 0) begin
		$display("TESTS PASSED");
	end else begin
		if (n_done != n_tbl)
			$display("Not every table entry reached the end of its data phase");
		$display("TESTS FAILED");
	end
	$finish;
end

// Watchdog, 40 cycles per table row
initial begin
	#(N_ENTRIES * 40 * CLK_PERIOD_NS);
	$display("Watchdog expired: the table did not finish within %0d cycles", N_ENTRIES * 40);
	$display("TESTS FAILED");
	$finish;
end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
ahb_lite_pkg.sv
cache_pkg.sv
cache_ram.sv
ahb_cache_ctrl.sv
ahb_writeback_cache.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv
